// File: nr_pbch_pkg.sv
`default_nettype none

package nr_pbch_pkg;

    // cell identity 0..1007 and the eight SSB index candidates
    localparam int unsigned N_ID_W = 10;
    localparam int unsigned NUM_IBAR = 8;
    localparam int unsigned IBAR_W = 3;

    // Gold sequence generator per 38.211 section 5.2.1
    localparam int unsigned GOLD_NC = 1600;
    localparam int unsigned LFSR_W = 31;

    // one PBCH symbol as seen by the detector
    localparam int unsigned NUM_SC = 256;
    localparam int unsigned PILOT_SPACING = 4;
    localparam int unsigned NUM_PILOTS = 64;
    localparam int unsigned PILOT_IDX_W = 6;

    // two bits per pilot give a correlation score of 0..128
    localparam int unsigned SCORE_W = 8;

    typedef logic [LFSR_W-1:0] lfsr_t;

    // phases of the DMRS sequence build that follows a new cell ID
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_SKIP,
        SEQ_GEN,
        SEQ_DONE
    } seq_phase_e;

endpackage

`default_nettype wire

// File: pbch_stream_pkg.sv
`default_nettype none

package pbch_stream_pkg;

    // width of one IQ component
    localparam int unsigned SAMPLE_W = 16;

    // bit position within the 128 generated Gold bits
    localparam int unsigned BIT_IDX_W = nr_pbch_pkg::PILOT_IDX_W + 1;

    // frequency domain sample with the imaginary part in the upper half
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] im;
        logic signed [SAMPLE_W-1:0] re;
    } iq_sample_t;

    // hard demodulated pilot, bit 1 from the real part and bit 0 from the imaginary part
    typedef struct packed {
        logic [1:0]                         bits;
        logic [nr_pbch_pkg::PILOT_IDX_W-1:0] idx;
        logic                               valid;
    } pilot_beat_t;

    // broadcast from the sequence controller to every correlation lane
    typedef struct packed {
        logic [nr_pbch_pkg::N_ID_W-1:0] n_id;
        nr_pbch_pkg::seq_phase_e        phase;
        logic                           x1;
        logic [BIT_IDX_W-1:0]           bit_idx;
    } seq_ctrl_t;

    typedef struct packed {
        logic [nr_pbch_pkg::IBAR_W-1:0]  ibar;
        logic [nr_pbch_pkg::SCORE_W-1:0] score;
    } ibar_result_t;

endpackage

`default_nettype wire

// File: dmrs_seq_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module dmrs_seq_ctrl (
    input  logic                             clk_i,
    input  logic                             reset_ni,
    input  logic [nr_pbch_pkg::N_ID_W-1:0]   n_id_i,
    input  logic                             n_id_valid_i,
    output pbch_stream_pkg::seq_ctrl_t       seq_ctrl_o,
    output logic [nr_pbch_pkg::N_ID_W-1:0]   n_id_o,
    output logic                             dmrs_ready_o
);

    nr_pbch_pkg::seq_phase_e                          phase_q;
    logic [nr_pbch_pkg::N_ID_W-1:0]                   n_id_q;
    logic [$clog2(nr_pbch_pkg::GOLD_NC)-1:0]          skip_cnt_q;
    logic [pbch_stream_pkg::BIT_IDX_W-1:0]            bit_cnt_q;
    nr_pbch_pkg::lfsr_t                               x1_q;
    nr_pbch_pkg::lfsr_t                               x1_next;

    // x1(n+31) = x1(n+3) + x1(n), the oldest bit sits at position 0
    assign x1_next = {x1_q[3] ^ x1_q[0], x1_q[nr_pbch_pkg::LFSR_W-1:1]};

    // the lanes step their own x2 on exactly the same edges as x1 below
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            phase_q    <= nr_pbch_pkg::SEQ_IDLE;
            n_id_q     <= '0;
            skip_cnt_q <= '0;
            bit_cnt_q  <= '0;
            x1_q       <= nr_pbch_pkg::lfsr_t'(1);
        end else if (n_id_valid_i) begin
            // a new cell ID always restarts the whole build
            phase_q <= nr_pbch_pkg::SEQ_LOAD;
            n_id_q  <= n_id_i;
        end else begin
            case (phase_q)
                nr_pbch_pkg::SEQ_LOAD: begin
                    x1_q       <= nr_pbch_pkg::lfsr_t'(1);
                    skip_cnt_q <= '0;
                    phase_q    <= nr_pbch_pkg::SEQ_SKIP;
                end
                nr_pbch_pkg::SEQ_SKIP: begin
                    x1_q <= x1_next;
                    if (skip_cnt_q == nr_pbch_pkg::GOLD_NC - 1) begin
                        bit_cnt_q <= '0;
                        phase_q   <= nr_pbch_pkg::SEQ_GEN;
                    end else begin
                        skip_cnt_q <= skip_cnt_q + 1'b1;
                    end
                end
                nr_pbch_pkg::SEQ_GEN: begin
                    // each of these cycles hands c(bit_cnt_q) to the lanes
                    x1_q <= x1_next;
                    if (bit_cnt_q == 2 * nr_pbch_pkg::NUM_PILOTS - 1) begin
                        phase_q <= nr_pbch_pkg::SEQ_DONE;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                default: begin
                    phase_q <= phase_q;
                end
            endcase
        end
    end

    always_comb begin
        seq_ctrl_o.n_id    = n_id_q;
        seq_ctrl_o.phase   = phase_q;
        seq_ctrl_o.x1      = x1_q[0];
        seq_ctrl_o.bit_idx = bit_cnt_q;
    end

    assign n_id_o       = n_id_q;
    assign dmrs_ready_o = (phase_q == nr_pbch_pkg::SEQ_DONE);

    // stored pilots stay valid until the next cell ID
    a_done_holds: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (phase_q == nr_pbch_pkg::SEQ_DONE && !n_id_valid_i)
            |=> (phase_q == nr_pbch_pkg::SEQ_DONE)
    );

endmodule

`default_nettype wire

// File: pbch_pilot_extract.sv
`timescale 1ns/10ps
`default_nettype none

module pbch_pilot_extract (
    input  logic                             clk_i,
    input  logic                             reset_ni,
    input  logic [nr_pbch_pkg::N_ID_W-1:0]   n_id_i,
    input  logic                             dmrs_ready_i,
    input  logic                             result_pending_i,
    input  logic                             pbch_start_i,
    input  pbch_stream_pkg::iq_sample_t      sample_i,
    input  logic                             sample_valid_i,
    output logic                             sample_ready_o,
    output pbch_stream_pkg::pilot_beat_t     pilot_o,
    output logic                             sym_clear_o,
    output logic                             sym_done_o
);

    logic                                    active_q;
    logic [$clog2(nr_pbch_pkg::NUM_SC)-1:0]  sc_q;
    logic [nr_pbch_pkg::PILOT_IDX_W:0]       pil_cnt_q;
    logic                                    pilot_vld_q;
    logic [1:0]                              pilot_bits_q;
    logic [nr_pbch_pkg::PILOT_IDX_W-1:0]     pilot_idx_q;
    logic                                    clear_q;
    logic                                    done_q;
    logic                                    start_ok;
    logic                                    accept;
    logic                                    is_pilot;
    logic                                    last_sc;

    assign start_ok = pbch_start_i && dmrs_ready_i && !active_q && !result_pending_i;
    assign accept   = sample_valid_i && active_q;
    assign last_sc  = accept && (sc_q == nr_pbch_pkg::NUM_SC - 1);

    // pilots sit on every fourth subcarrier, shifted by N_id mod 4
    assign is_pilot = (sc_q % nr_pbch_pkg::PILOT_SPACING) ==
                      (n_id_i % nr_pbch_pkg::PILOT_SPACING);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            active_q    <= 1'b0;
            sc_q        <= '0;
            pil_cnt_q   <= '0;
            pilot_vld_q <= 1'b0;
            clear_q     <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            clear_q     <= start_ok;
            done_q      <= last_sc;
            pilot_vld_q <= accept && is_pilot;
            if (start_ok) begin
                active_q  <= 1'b1;
                sc_q      <= '0;
                pil_cnt_q <= '0;
            end else if (accept) begin
                sc_q <= sc_q + 1'b1;
                if (is_pilot) begin
                    pil_cnt_q <= pil_cnt_q + 1'b1;
                end
                if (last_sc) begin
                    active_q <= 1'b0;
                end
            end
        end
    end

    // hard decision keeps only the sign of each component
    always_ff @(posedge clk_i) begin
        if (accept && is_pilot) begin
            pilot_bits_q <= {sample_i.re[pbch_stream_pkg::SAMPLE_W-1],
                             sample_i.im[pbch_stream_pkg::SAMPLE_W-1]};
            pilot_idx_q  <= pil_cnt_q[nr_pbch_pkg::PILOT_IDX_W-1:0];
        end
    end

    always_comb begin
        pilot_o.bits  = pilot_bits_q;
        pilot_o.idx   = pilot_idx_q;
        pilot_o.valid = pilot_vld_q;
    end

    assign sample_ready_o = active_q;
    assign sym_clear_o    = clear_q;
    assign sym_done_o     = done_q;

    // the pilot count must stay within one symbol's pilots for any N_id offset
    a_pilot_idx_range: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (accept && is_pilot) |-> (pil_cnt_q < nr_pbch_pkg::NUM_PILOTS)
    );

endmodule

`default_nettype wire

// File: dmrs_corr_lane.sv
`timescale 1ns/10ps
`default_nettype none

module dmrs_corr_lane #(
    parameter int unsigned LANE_IBAR = 0
) (
    input  logic                              clk_i,
    input  logic                              reset_ni,
    input  pbch_stream_pkg::seq_ctrl_t        seq_ctrl_i,
    input  pbch_stream_pkg::pilot_beat_t      pilot_i,
    input  logic                              sym_clear_i,
    output logic [nr_pbch_pkg::SCORE_W-1:0]   score_o
);

    nr_pbch_pkg::lfsr_t                  x2_q;
    nr_pbch_pkg::lfsr_t                  x2_next;
    nr_pbch_pkg::lfsr_t                  ibar_p1;
    nr_pbch_pkg::lfsr_t                  n_div4_p1;
    nr_pbch_pkg::lfsr_t                  c_init;
    logic [1:0]                          mem_q [nr_pbch_pkg::NUM_PILOTS];
    logic                                hi_q;
    logic                                gold_bit;
    logic [1:0]                          ref_bits;
    logic [1:0]                          match_cnt;
    logic [nr_pbch_pkg::SCORE_W-1:0]     score_q;

    // c_init = (ibar+1)(N_id/4+1) * 2^11 + (ibar+1) * 2^6 + N_id mod 4
    assign ibar_p1   = nr_pbch_pkg::lfsr_t'(LANE_IBAR + 1);
    assign n_div4_p1 = nr_pbch_pkg::lfsr_t'(seq_ctrl_i.n_id[nr_pbch_pkg::N_ID_W-1:2]) +
                       nr_pbch_pkg::lfsr_t'(1);
    assign c_init    = ((ibar_p1 * n_div4_p1) << 11) + (ibar_p1 << 6) +
                       nr_pbch_pkg::lfsr_t'(seq_ctrl_i.n_id[1:0]);

    // x2(n+31) = x2(n+3) + x2(n+2) + x2(n+1) + x2(n)
    assign x2_next  = {x2_q[3] ^ x2_q[2] ^ x2_q[1] ^ x2_q[0],
                       x2_q[nr_pbch_pkg::LFSR_W-1:1]};
    assign gold_bit = seq_ctrl_i.x1 ^ x2_q[0];

    // the even bit waits in hi_q so a whole pilot is written on the odd bit
    always_ff @(posedge clk_i) begin
        case (seq_ctrl_i.phase)
            nr_pbch_pkg::SEQ_LOAD: begin
                x2_q <= c_init;
            end
            nr_pbch_pkg::SEQ_SKIP: begin
                x2_q <= x2_next;
            end
            nr_pbch_pkg::SEQ_GEN: begin
                x2_q <= x2_next;
                if (!seq_ctrl_i.bit_idx[0]) begin
                    hi_q <= gold_bit;
                end else begin
                    mem_q[seq_ctrl_i.bit_idx[pbch_stream_pkg::BIT_IDX_W-1:1]] <=
                        {hi_q, gold_bit};
                end
            end
            default: begin
                x2_q <= x2_q;
            end
        endcase
    end

    assign ref_bits  = mem_q[pilot_i.idx];
    assign match_cnt = {1'b0, ~(ref_bits[1] ^ pilot_i.bits[1])} +
                       {1'b0, ~(ref_bits[0] ^ pilot_i.bits[0])};

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            score_q <= '0;
        end else if (sym_clear_i) begin
            score_q <= '0;
        end else if (pilot_i.valid) begin
            score_q <= score_q + {{(nr_pbch_pkg::SCORE_W-2){1'b0}}, match_cnt};
        end
    end

    assign score_o = score_q;

    // at most two matches per pilot and one beat per pilot index in a symbol
    a_score_range: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        score_q <= 2 * nr_pbch_pkg::NUM_PILOTS
    );

endmodule

`default_nettype wire

// File: ibar_select.sv
`timescale 1ns/10ps
`default_nettype none

module ibar_select (
    input  logic                                                  clk_i,
    input  logic                                                  reset_ni,
    input  logic [nr_pbch_pkg::NUM_IBAR-1:0][nr_pbch_pkg::SCORE_W-1:0] scores_i,
    input  logic                                                  sym_done_i,
    output pbch_stream_pkg::ibar_result_t                         result_o,
    output logic                                                  result_valid_o,
    input  logic                                                  result_ready_i,
    output logic                                                  result_pending_o
);

    pbch_stream_pkg::ibar_result_t  best;
    pbch_stream_pkg::ibar_result_t  result_q;
    logic                           done_d_q;
    logic                           valid_q;

    // strict compare keeps the lowest index on a tie
    always_comb begin
        best.ibar  = '0;
        best.score = scores_i[0];
        for (int i = 1; i < nr_pbch_pkg::NUM_IBAR; i++) begin
            if (scores_i[i] > best.score) begin
                best.ibar  = i[nr_pbch_pkg::IBAR_W-1:0];
                best.score = scores_i[i];
            end
        end
    end

    // the last pilot lands in the lane scores one cycle after sym_done_i
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            done_d_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            done_d_q <= sym_done_i;
            if (done_d_q) begin
                valid_q <= 1'b1;
            end else if (result_ready_i) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (done_d_q) begin
            result_q <= best;
        end
    end

    assign result_o         = result_q;
    assign result_valid_o   = valid_q;
    assign result_pending_o = sym_done_i || done_d_q || valid_q;

    a_result_stable: assert property (
        @(posedge clk_i) disable iff (!reset_ni)
        (valid_q && !result_ready_i) |=> (valid_q && $stable(result_q))
    );

endmodule

`default_nettype wire

// File: pbch_dmrs_detect.sv
`timescale 1ns/10ps
`default_nettype none

module pbch_dmrs_detect (
    input  logic                             clk_i,
    input  logic                             reset_ni,
    input  logic [nr_pbch_pkg::N_ID_W-1:0]   n_id_i,
    input  logic                             n_id_valid_i,
    input  logic                             pbch_start_i,
    input  pbch_stream_pkg::iq_sample_t      sample_i,
    input  logic                             sample_valid_i,
    output logic                             sample_ready_o,
    output logic                             dmrs_ready_o,
    output pbch_stream_pkg::ibar_result_t    result_o,
    output logic                             result_valid_o,
    input  logic                             result_ready_i
);

    pbch_stream_pkg::seq_ctrl_t                                seq_ctrl;
    pbch_stream_pkg::pilot_beat_t                              pilot;
    logic [nr_pbch_pkg::N_ID_W-1:0]                            n_id;
    logic                                                      sym_clear;
    logic                                                      sym_done;
    logic                                                      result_pending;
    logic [nr_pbch_pkg::NUM_IBAR-1:0][nr_pbch_pkg::SCORE_W-1:0] scores;

    dmrs_seq_ctrl u_seq_ctrl (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .n_id_i       (n_id_i),
        .n_id_valid_i (n_id_valid_i),
        .seq_ctrl_o   (seq_ctrl),
        .n_id_o       (n_id),
        .dmrs_ready_o (dmrs_ready_o)
    );

    pbch_pilot_extract u_pilot_extract (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .n_id_i           (n_id),
        .dmrs_ready_i     (dmrs_ready_o),
        .result_pending_i (result_pending),
        .pbch_start_i     (pbch_start_i),
        .sample_i         (sample_i),
        .sample_valid_i   (sample_valid_i),
        .sample_ready_o   (sample_ready_o),
        .pilot_o          (pilot),
        .sym_clear_o      (sym_clear),
        .sym_done_o       (sym_done)
    );

    // one lane per SSB index candidate
    for (genvar g = 0; g < nr_pbch_pkg::NUM_IBAR; g++) begin : gen_lane
        dmrs_corr_lane #(
            .LANE_IBAR (g)
        ) u_lane (
            .clk_i       (clk_i),
            .reset_ni    (reset_ni),
            .seq_ctrl_i  (seq_ctrl),
            .pilot_i     (pilot),
            .sym_clear_i (sym_clear),
            .score_o     (scores[g])
        );
    end

    ibar_select u_select (
        .clk_i            (clk_i),
        .reset_ni         (reset_ni),
        .scores_i         (scores),
        .sym_done_i       (sym_done),
        .result_o         (result_o),
        .result_valid_o   (result_valid_o),
        .result_ready_i   (result_ready_i),
        .result_pending_o (result_pending)
    );

endmodule

`default_nettype wire

// File: tb_pbch_tasks.svh
`ifndef TB_PBCH_TASKS_SVH
`define TB_PBCH_TASKS_SVH

// one step of the LCG, the upper bits are the useful ones
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * LCG_MUL + LCG_INC;
    return lcg_state;
endfunction

// c(0..127) of the Gold sequence for one cell ID and SSB index, after the skipped outputs
function automatic logic [127:0] gold_seq(input int unsigned nid, input int unsigned ibar);
    logic        x1 [0:1758];
    logic        x2 [0:1758];
    int unsigned c_init;
    logic [127:0] c;
    c_init = ((ibar + 1) * (nid / 4 + 1)) * 2048 + (ibar + 1) * 64 + nid % 4;
    for (int n = 0; n < 31; n++) begin
        x1[n] = (n == 0);
        x2[n] = c_init[n];
    end
    for (int n = 0; n < nr_pbch_pkg::GOLD_NC + 128; n++) begin
        x1[n+31] = x1[n+3] ^ x1[n];
        x2[n+31] = x2[n+3] ^ x2[n+2] ^ x2[n+1] ^ x2[n];
    end
    for (int n = 0; n < 128; n++) begin
        c[n] = x1[n+nr_pbch_pkg::GOLD_NC] ^ x2[n+nr_pbch_pkg::GOLD_NC];
    end
    return c;
endfunction

task automatic load_reference(input int unsigned nid);
    cur_nid = nid;
    for (int i = 0; i < nr_pbch_pkg::NUM_IBAR; i++) begin
        ref_seq[i] = gold_seq(nid, i);
    end
endtask

// random data everywhere, then the chosen lane's signs on the pilot subcarriers
task automatic build_clean_symbol(input int unsigned ibar);
    int m;
    for (int k = 0; k < nr_pbch_pkg::NUM_SC; k++) begin
        sym_buf[k] = lcg_next();
        if (k % nr_pbch_pkg::PILOT_SPACING == cur_nid % nr_pbch_pkg::PILOT_SPACING) begin
            m = k / nr_pbch_pkg::PILOT_SPACING;
            sym_buf[k].re[15] = ref_seq[ibar][2*m];
            sym_buf[k].im[15] = ref_seq[ibar][2*m+1];
        end
    end
endtask

task automatic build_random_symbol();
    for (int k = 0; k < nr_pbch_pkg::NUM_SC; k++) begin
        sym_buf[k] = lcg_next();
    end
endtask

// score every candidate against the symbol buffer, the first maximum wins
function automatic pbch_stream_pkg::ibar_result_t expected_result();
    pbch_stream_pkg::ibar_result_t best;
    int score;
    int m;
    best = '0;
    for (int i = 0; i < nr_pbch_pkg::NUM_IBAR; i++) begin
        score = 0;
        for (int k = 0; k < nr_pbch_pkg::NUM_SC; k++) begin
            if (k % nr_pbch_pkg::PILOT_SPACING == cur_nid % nr_pbch_pkg::PILOT_SPACING) begin
                m = k / nr_pbch_pkg::PILOT_SPACING;
                score += (sym_buf[k].re[15] == ref_seq[i][2*m]);
                score += (sym_buf[k].im[15] == ref_seq[i][2*m+1]);
            end
        end
        if (i == 0 || score > best.score) begin
            best.ibar  = i[nr_pbch_pkg::IBAR_W-1:0];
            best.score = score[nr_pbch_pkg::SCORE_W-1:0];
        end
    end
    return best;
endfunction

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s expected %b actual %b", name, exp, act);
        err_count++;
    end
endtask

task automatic check_result(input string name, input pbch_stream_pkg::ibar_result_t exp,
                            input pbch_stream_pkg::ibar_result_t act);
    if (act !== exp) begin
        $display("ERR %s expected ibar %0d score %0d actual ibar %0d score %0d",
                 name, exp.ibar, exp.score, act.ibar, act.score);
        err_count++;
    end
endtask

`endif

// File: tb_pbch_dmrs_detect.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pbch_dmrs_detect;

    localparam int CLK_HALF = 2;
    localparam logic [31:0] LCG_SEED = 32'd42;
    localparam logic [31:0] LCG_MUL = 32'd1664525;
    localparam logic [31:0] LCG_INC = 32'd1013904223;
    // three sequence builds of 1730 cycles plus about two dozen symbols with gaps
    localparam int TIMEOUT_CYCLES = 20000;

    logic                                clk;
    logic                                rst_n;
    logic [nr_pbch_pkg::N_ID_W-1:0]      n_id;
    logic                                n_id_valid;
    logic                                pbch_start;
    pbch_stream_pkg::iq_sample_t         sample;
    logic                                sample_valid;
    logic                                sample_ready;
    logic                                dmrs_ready;
    pbch_stream_pkg::ibar_result_t       result;
    logic                                result_valid;
    logic                                result_ready;

    logic [31:0]                         lcg_state = LCG_SEED;
    int                                  err_count = 0;
    int                                  cycle_count = 0;
    int unsigned                         cur_nid = 0;
    pbch_stream_pkg::iq_sample_t         sym_buf [nr_pbch_pkg::NUM_SC];
    logic [127:0]                        ref_seq [nr_pbch_pkg::NUM_IBAR];

    `include "tb_pbch_tasks.svh"

    pbch_dmrs_detect DUT (
        .clk_i          (clk),
        .reset_ni       (rst_n),
        .n_id_i         (n_id),
        .n_id_valid_i   (n_id_valid),
        .pbch_start_i   (pbch_start),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .sample_ready_o (sample_ready),
        .dmrs_ready_o   (dmrs_ready),
        .result_o       (result),
        .result_valid_o (result_valid),
        .result_ready_i (result_ready)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic pulse_start();
        pbch_start = 1'b1;
        next_cycle();
        pbch_start = 1'b0;
    endtask

    task automatic set_cell_id(input int unsigned nid, input string name);
        n_id       = nid[nr_pbch_pkg::N_ID_W-1:0];
        n_id_valid = 1'b1;
        next_cycle();
        n_id_valid = 1'b0;
        check_bit({name, " ready drops"}, 1'b0, dmrs_ready);
        repeat (1728) next_cycle();
        check_bit({name, " ready early"}, 1'b0, dmrs_ready);
        next_cycle();
        check_bit({name, " ready"}, 1'b1, dmrs_ready);
        load_reference(nid);
    endtask

    // sends the buffered symbol, optionally with random holes in sample_valid
    task automatic send_symbol(input bit gaps);
        int          idx;
        logic        take;
        logic [31:0] roll;
        pulse_start();
        if (sample_ready !== 1'b1) begin
            $display("PBCH start was not accepted by the DUT");
            err_count++;
            return;
        end
        idx = 0;
        while (idx < nr_pbch_pkg::NUM_SC) begin
            roll = lcg_next();
            take = !(gaps && roll[31:30] == 2'b00);
            sample_valid = take;
            if (take) begin
                sample = sym_buf[idx];
            end else begin
                sample = roll;
            end
            if (take && sample_ready) begin
                idx++;
            end
            next_cycle();
        end
        sample_valid = 1'b0;
    endtask

    // the result must appear exactly three cycles after the last sample
    task automatic await_result(input string name, input pbch_stream_pkg::ibar_result_t exp);
        check_bit({name, " valid early"}, 1'b0, result_valid);
        next_cycle();
        check_bit({name, " valid early"}, 1'b0, result_valid);
        next_cycle();
        check_bit({name, " valid"}, 1'b1, result_valid);
        check_result(name, exp, result);
    endtask

    task automatic run_detection(input string name, input pbch_stream_pkg::ibar_result_t exp,
                                 input bit gaps);
        send_symbol(gaps);
        await_result(name, exp);
        next_cycle();
        check_bit({name, " handshake"}, 1'b0, result_valid);
    endtask

    task automatic test_reset();
        check_bit("reset dmrs_ready", 1'b0, dmrs_ready);
        check_bit("reset sample_ready", 1'b0, sample_ready);
        check_bit("reset result_valid", 1'b0, result_valid);
        pulse_start();
        check_bit("start before cell id", 1'b0, sample_ready);
        next_cycle();
        check_bit("start before cell id", 1'b0, sample_ready);
    endtask

    task automatic test_clean_symbol();
        int unsigned                   nids [2] = '{0, 397};
        pbch_stream_pkg::ibar_result_t exp;
        foreach (nids[j]) begin
            set_cell_id(nids[j], $sformatf("cell id %0d", nids[j]));
            for (int i = 0; i < nr_pbch_pkg::NUM_IBAR; i++) begin
                build_clean_symbol(i);
                exp.ibar  = i[nr_pbch_pkg::IBAR_W-1:0];
                exp.score = 8'd128;
                run_detection($sformatf("clean nid %0d ibar %0d", nids[j], i), exp, 1'b0);
            end
        end
    endtask

    task automatic test_random_symbol();
        for (int r = 0; r < 3; r++) begin
            build_random_symbol();
            run_detection($sformatf("random symbol %0d", r), expected_result(), 1'b0);
        end
    endtask

    task automatic test_backpressure();
        pbch_stream_pkg::ibar_result_t exp;
        build_clean_symbol(3);
        exp = expected_result();
        result_ready = 1'b0;
        send_symbol(1'b0);
        await_result("backpressure", exp);
        repeat (5) begin
            next_cycle();
            check_bit("backpressure valid held", 1'b1, result_valid);
            check_result("backpressure result held", exp, result);
            check_bit("backpressure sample_ready", 1'b0, sample_ready);
        end
        pulse_start();
        check_bit("start while pending", 1'b0, sample_ready);
        next_cycle();
        check_bit("start while pending", 1'b0, sample_ready);
        result_ready = 1'b1;
        next_cycle();
        check_bit("backpressure release", 1'b0, result_valid);
        // the same symbol with and without holes in sample_valid
        build_random_symbol();
        exp = expected_result();
        run_detection("no gaps", exp, 1'b0);
        run_detection("with gaps", exp, 1'b1);
    endtask

    task automatic test_new_cell_id();
        pbch_stream_pkg::ibar_result_t exp;
        build_random_symbol();
        exp = expected_result();
        result_ready = 1'b0;
        send_symbol(1'b0);
        await_result("before new cell id", exp);
        set_cell_id(1003, "new cell id");
        check_bit("pending across rebuild", 1'b1, result_valid);
        check_result("pending across rebuild", exp, result);
        result_ready = 1'b1;
        next_cycle();
        build_clean_symbol(5);
        exp.ibar  = 3'd5;
        exp.score = 8'd128;
        run_detection("new cell id ibar 5", exp, 1'b0);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        n_id         = '0;
        n_id_valid   = 1'b0;
        pbch_start   = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        result_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_clean_symbol();
        test_random_symbol();
        test_backpressure();
        test_new_cell_id();
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pbch_dmrs_detect.f
+incdir+.
nr_pbch_pkg.sv
pbch_stream_pkg.sv
dmrs_seq_ctrl.sv
pbch_pilot_extract.sv
dmrs_corr_lane.sv
ibar_select.sv
pbch_dmrs_detect.sv
tb_pbch_dmrs_detect.sv

// File: Bender.yml
package:
  name: pbch_dmrs_detect

sources:
  - nr_pbch_pkg.sv
  - pbch_stream_pkg.sv
  - dmrs_seq_ctrl.sv
  - pbch_pilot_extract.sv
  - dmrs_corr_lane.sv
  - ibar_select.sv
  - pbch_dmrs_detect.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pbch_dmrs_detect.sv
